// ==== backend.sv ====
module backend
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_i,
	input  inst_t   [PIPE_NUM-1:0]     inst_i,
	input  logic    [PIPE_NUM-1:0]     inst_valid_i,
	input  logic                       hold_i,
	output logic    [ISSUE_NUM_W-1:0]  issue_num_o,
	output commit_t [PIPE_NUM-1:0]     commit_o
);

	// issue to pipes
	exec_req_t [PIPE_NUM-1:0] req;
	// pipes back to issue for bypass
	fwd_t [PIPE_NUM-1:0] fwd_ex;
	fwd_t [PIPE_NUM-1:0] fwd_wb;
	// pipes to rf
	commit_t [PIPE_NUM-1:0] wb;
	// operand reads
	logic [RD_PORT_NUM-1:0][REG_AW-1:0] rf_addr;
	logic [RD_PORT_NUM-1:0][XLEN-1:0]   rf_data;

	issue_unit i_issue_unit (
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.hold_i       (hold_i),
		.fwd_ex_i     (fwd_ex),
		.fwd_wb_i     (fwd_wb),
		.rf_data_i    (rf_data),
		.rf_addr_o    (rf_addr),
		.req_o        (req),
		.issue_num_o  (issue_num_o)
	);

	// pipe 0 takes the older instruction
	for (genvar p = 0; p < PIPE_NUM; p++) begin : g_pipe
		exec_pipe i_exec_pipe (
			.clk      (clk),
			.rst_i    (rst_i),
			.req_i    (req[p]),
			.fwd_ex_o (fwd_ex[p]),
			.fwd_wb_o (fwd_wb[p]),
			.wb_o     (wb[p])
		);
	end

	reg_file i_reg_file (
		.clk      (clk),
		.rst_i    (rst_i),
		.wb_i     (wb),
		.r_addr_i (rf_addr),
		.r_data_o (rf_data),
		.commit_o (commit_o)
	);

endmodule

// ==== exec_pipe.sv ====
module exec_pipe
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst_i,
	input  exec_req_t req_i,
	output fwd_t      fwd_ex_o,
	output fwd_t      fwd_wb_o,
	output commit_t   wb_o
);

	// ex stage register
	exec_req_t ex_q;
	// wb stage register
	commit_t wb_q;
	// alu output in ex
	logic [XLEN-1:0] ex_result;
	logic [SHAMT_W-1:0] shamt;

	// only the valid bits see reset
	always_ff @(posedge clk) begin
		ex_q <= req_i;
		wb_q <= '{
			valid: ex_q.valid,
			pc:    ex_q.pc,
			rd:    ex_q.rd,
			w_reg: ex_q.w_reg,
			data:  ex_result
		};
		if (rst_i) begin
			ex_q.valid <= 1'b0;
			wb_q.valid <= 1'b0;
		end
	end

	// alu
	always_comb begin
		shamt = ex_q.b[SHAMT_W-1:0];
		case (ex_q.op)
			ADD:  ex_result = ex_q.a + ex_q.b;
			SUB:  ex_result = ex_q.a - ex_q.b;
			AND:  ex_result = ex_q.a & ex_q.b;
			OR:   ex_result = ex_q.a | ex_q.b;
			XOR:  ex_result = ex_q.a ^ ex_q.b;
			SLT:  ex_result = {{(XLEN-1){1'b0}}, $signed(ex_q.a) < $signed(ex_q.b)};
			SLTU: ex_result = {{(XLEN-1){1'b0}}, ex_q.a < ex_q.b};
			SLL:  ex_result = ex_q.a << shamt;
			SRL:  ex_result = ex_q.a >> shamt;
			// sign fill from bit 31
			SRA:  ex_result = $unsigned($signed(ex_q.a) >>> shamt);
			// b carries the zero-extended upper immediate
			LUI:  ex_result = ex_q.b << LUI_SHIFT;
			default: ex_result = '0;
		endcase
	end

	// bypass from ex, result is ready in the same cycle
	always_comb begin
		fwd_ex_o.valid = ex_q.valid && ex_q.w_reg && ex_q.rd != '0;
		fwd_ex_o.rd    = ex_q.rd;
		fwd_ex_o.data  = ex_result;
	end

	// bypass from wb, covers the cycle before the rf write lands
	always_comb begin
		fwd_wb_o.valid = wb_q.valid && wb_q.w_reg && wb_q.rd != '0;
		fwd_wb_o.rd    = wb_q.rd;
		fwd_wb_o.data  = wb_q.data;
	end

	assign wb_o = wb_q;

	// nothing enters wb without passing ex
	a_wb_after_ex: assert property (@(posedge clk) disable iff (rst_i)
		wb_q.valid |-> $past(ex_q.valid));

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

	// datapath width
	localparam int XLEN = 32;
	// architectural register count, x0 included
	localparam int REG_NUM = 32;
	localparam int REG_AW = 5;
	// raw immediate field as delivered by decode
	localparam int IMM_W = 20;
	// lui places the immediate in the upper bits
	localparam int LUI_SHIFT = 12;
	// shift amount comes from the low bits of operand b
	localparam int SHAMT_W = 5;

	// integer alu operations
	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		// signed compare
		SLT,
		// unsigned compare
		SLTU,
		SLL,
		SRL,
		// arithmetic right shift, sign fill
		SRA,
		LUI
	} alu_op_e;

	// one decoded instruction from the front end
	typedef struct packed {
		logic [XLEN-1:0]   pc;
		alu_op_e           op;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		// operand b from imm instead of rs2
		logic              use_imm;
		logic [IMM_W-1:0]  imm;
		// rd gets written
		logic              w_reg;
	} inst_t;

	// widen the raw immediate to a full operand
	// lui keeps it unsigned, the alu shifts it into place
	function automatic logic [XLEN-1:0] imm_ext(input inst_t inst);
		if (inst.op == LUI) begin
			return {{(XLEN-IMM_W){1'b0}}, inst.imm};
		end
		return {{(XLEN-IMM_W){inst.imm[IMM_W-1]}}, inst.imm};
	endfunction

endpackage

// ==== issue_unit.sv ====
module issue_unit
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  inst_t     [PIPE_NUM-1:0]                 inst_i,
	input  logic      [PIPE_NUM-1:0]                 inst_valid_i,
	input  logic                                     hold_i,
	input  fwd_t      [PIPE_NUM-1:0]                 fwd_ex_i,
	input  fwd_t      [PIPE_NUM-1:0]                 fwd_wb_i,
	input  logic      [RD_PORT_NUM-1:0][XLEN-1:0]    rf_data_i,
	output logic      [RD_PORT_NUM-1:0][REG_AW-1:0]  rf_addr_o,
	output exec_req_t [PIPE_NUM-1:0]                 req_o,
	output logic      [ISSUE_NUM_W-1:0]              issue_num_o
);

	// slot 1 reads what slot 0 writes
	logic dep_raw;
	// resolved register operands, same order as read ports
	logic [RD_PORT_NUM-1:0][XLEN-1:0] opnd;

	// pick the youngest in-flight producer of rs
	function automatic logic [XLEN-1:0] bypass(
		input logic [REG_AW-1:0]   rs,
		input logic [XLEN-1:0]     rf_val,
		input fwd_t [PIPE_NUM-1:0] ex,
		input fwd_t [PIPE_NUM-1:0] wb
	);
		logic [XLEN-1:0] val;
		// oldest source first so younger hits overwrite
		val = rf_val;
		for (int p = 0; p < PIPE_NUM; p++) begin
			if (wb[p].valid && wb[p].rd == rs) begin
				val = wb[p].data;
			end
		end
		for (int p = 0; p < PIPE_NUM; p++) begin
			if (ex[p].valid && ex[p].rd == rs) begin
				val = ex[p].data;
			end
		end
		// x0 is never forwarded
		if (rs == '0) begin
			val = '0;
		end
		return val;
	endfunction

	// two read ports per slot, rs1 on even, rs2 on odd
	always_comb begin
		for (int p = 0; p < PIPE_NUM; p++) begin
			rf_addr_o[2*p]   = inst_i[p].rs1;
			rf_addr_o[2*p+1] = inst_i[p].rs2;
		end
	end

	always_comb begin
		for (int i = 0; i < RD_PORT_NUM; i++) begin
			opnd[i] = bypass(rf_addr_o[i], rf_data_i[i], fwd_ex_i, fwd_wb_i);
		end
	end

	// raw hazard inside the pair
	// rs2 only counts when it is really read
	always_comb begin
		dep_raw = 1'b0;
		if (inst_i[0].w_reg && inst_i[0].rd != '0) begin
			dep_raw = (inst_i[1].rs1 == inst_i[0].rd) ||
				(!inst_i[1].use_imm && inst_i[1].rs2 == inst_i[0].rd);
		end
	end

	// in-order issue, no pair when dependent
	always_comb begin
		if (hold_i || !inst_valid_i[0]) begin
			issue_num_o = ISSUE_NUM_W'(0);
		end else if (inst_valid_i[1] && !dep_raw) begin
			issue_num_o = ISSUE_NUM_W'(2);
		end else begin
			issue_num_o = ISSUE_NUM_W'(1);
		end
	end

	// slot p always goes to pipe p
	always_comb begin
		for (int p = 0; p < PIPE_NUM; p++) begin
			req_o[p].valid = issue_num_o > ISSUE_NUM_W'(p);
			req_o[p].pc    = inst_i[p].pc;
			req_o[p].op    = inst_i[p].op;
			req_o[p].rd    = inst_i[p].rd;
			req_o[p].w_reg = inst_i[p].w_reg;
			req_o[p].a     = opnd[2*p];
			// imm replaces rs2
			req_o[p].b     = inst_i[p].use_imm ? imm_ext(inst_i[p]) : opnd[2*p+1];
		end
	end

	// slot 1 is only meaningful behind a valid slot 0
	always_comb begin
		if (!$isunknown({hold_i, inst_valid_i})) begin
			a_issue_le_valid: assert (issue_num_o <=
				ISSUE_NUM_W'(inst_valid_i[0]) +
				ISSUE_NUM_W'(inst_valid_i[0] & inst_valid_i[1]));
		end
	end

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

	import isa_pkg::*;

	// identical execute pipes
	localparam int PIPE_NUM = 2;
	// rs1 and rs2 for every pipe
	localparam int RD_PORT_NUM = 2 * PIPE_NUM;
	// issue count 0, 1 or 2
	localparam int ISSUE_NUM_W = 2;

	// request handed from issue to one pipe
	// operands already resolved, imm already substituted
	typedef struct packed {
		logic              valid;
		logic [XLEN-1:0]   pc;
		alu_op_e           op;
		logic [REG_AW-1:0] rd;
		logic              w_reg;
		logic [XLEN-1:0]   a;
		logic [XLEN-1:0]   b;
	} exec_req_t;

	// bypass view of one pipe stage
	// valid only for a writing instruction with rd != 0
	typedef struct packed {
		logic              valid;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   data;
	} fwd_t;

	// retired instruction, also the rf write request
	typedef struct packed {
		logic              valid;
		logic [XLEN-1:0]   pc;
		logic [REG_AW-1:0] rd;
		logic              w_reg;
		logic [XLEN-1:0]   data;
	} commit_t;

endpackage

// ==== reg_file.sv ====
module reg_file
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic    clk,
	input  logic    rst_i,
	input  commit_t [PIPE_NUM-1:0]                wb_i,
	input  logic    [RD_PORT_NUM-1:0][REG_AW-1:0] r_addr_i,
	output logic    [RD_PORT_NUM-1:0][XLEN-1:0]   r_data_o,
	output commit_t [PIPE_NUM-1:0]                commit_o
);

	// x1..x31, x0 has no storage
	logic [XLEN-1:0] regs_q [1:REG_NUM-1];
	// some pipe retires a write aimed at x0
	logic x0_write;

	// later pipe wins on the same rd since its write comes last
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 1; i < REG_NUM; i++) begin
				regs_q[i] <= '0;
			end
		end else begin
			for (int p = 0; p < PIPE_NUM; p++) begin
				if (wb_i[p].valid && wb_i[p].w_reg && wb_i[p].rd != '0) begin
					regs_q[wb_i[p].rd] <= wb_i[p].data;
				end
			end
		end
	end

	// plain reads, the issue unit bypasses anything newer
	always_comb begin
		for (int i = 0; i < RD_PORT_NUM; i++) begin
			if (r_addr_i[i] == '0) begin
				r_data_o[i] = '0;
			end else begin
				r_data_o[i] = regs_q[r_addr_i[i]];
			end
		end
	end

	// wb entries retire in the cycle they are written
	always_comb begin
		for (int p = 0; p < PIPE_NUM; p++) begin
			commit_o[p] = wb_i[p];
			// nothing retires while reset is held
			commit_o[p].valid = wb_i[p].valid && !rst_i;
		end
	end

	always_comb begin
		x0_write = 1'b0;
		for (int p = 0; p < PIPE_NUM; p++) begin
			x0_write |= wb_i[p].valid && wb_i[p].w_reg && wb_i[p].rd == '0;
		end
	end

	// a dropped x0 write never shows up on a later read
	for (genvar g = 0; g < RD_PORT_NUM; g++) begin : g_x0_chk
		a_x0_read_zero: assert property (@(posedge clk) disable iff (rst_i)
			x0_write |=> (r_addr_i[g] != '0 || r_data_o[g] == '0));
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the backend testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_backend -o tb_backend
# a failed assertion stops the binary, the log search below decides
./obj_dir/tb_backend > sim.log 2>&1 || true
cat sim.log
if grep -q "Testbench failed" sim.log; then
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi

// ==== sim.f ====
isa_pkg.sv
pipe_pkg.sv
issue_unit.sv
exec_pipe.sv
reg_file.sv
backend.sv
tb_clock.sv
tb_backend.sv

// ==== tb_backend.sv ====
module tb_backend
	import isa_pkg::*;
	import pipe_pkg::*;
();

	typedef enum {M_PAIR, M_SINGLE, M_HOLD, M_RAND} drive_mode_e;

	logic clk;
	logic rst;
	inst_t [PIPE_NUM-1:0] inst;
	logic [PIPE_NUM-1:0] inst_valid;
	logic hold;
	logic [ISSUE_NUM_W-1:0] issue_num;
	commit_t [PIPE_NUM-1:0] commit;

	// reference model state, x0 stays 0
	logic [XLEN-1:0] model_regs [REG_NUM];
	// expected commits in program order, with the cycle they are due
	commit_t exp_q[$];
	int exp_cyc_q[$];
	inst_t q_single[$];
	inst_t q_pair[$];
	inst_t q_dep[$];
	inst_t q_chain[$];
	inst_t q_x0[$];
	inst_t q_hold[$];
	inst_t q_rand[$];
	int seed;
	int cyc = 0;
	int total_insts = 0;
	logic [XLEN-1:0] next_pc;
	int err_commit;
	int err_issue;
	int err_other;
	string test_name;

	tb_clock i_tb_clock (.clk_o(clk));

	backend i_backend (
		.clk          (clk),
		.rst_i        (rst),
		.inst_i       (inst),
		.inst_valid_i (inst_valid),
		.hold_i       (hold),
		.issue_num_o  (issue_num),
		.commit_o     (commit)
	);

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// alu semantics straight from the isa rules
	function automatic logic [XLEN-1:0] ref_alu(input inst_t in, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] rb);
		logic [XLEN-1:0] b;
		b = in.use_imm ? {{(XLEN-IMM_W){in.imm[IMM_W-1]}}, in.imm} : rb;
		case (in.op)
			ADD:  return a + b;
			SUB:  return a - b;
			AND:  return a & b;
			OR:   return a | b;
			XOR:  return a ^ b;
			SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			SLTU: return (a < b) ? 32'd1 : 32'd0;
			SLL:  return a << b[4:0];
			SRL:  return a >> b[4:0];
			// logical shift, then fill the vacated top bits with the sign
			SRA:  return (a >> b[4:0]) | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> b[4:0]));
			LUI:  return {in.imm, 12'h000};
			default: return '0;
		endcase
	endfunction

	function automatic inst_t mk(input alu_op_e op, input int rd, input int rs1, input int rs2,
		input logic use_imm, input int imm);
		inst_t t;
		t.pc = '0;
		t.op = op;
		t.rd = REG_AW'(rd);
		t.rs1 = REG_AW'(rs1);
		t.rs2 = REG_AW'(rs2);
		// lui always takes its operand from imm
		t.use_imm = use_imm || op == LUI;
		t.imm = IMM_W'(imm);
		t.w_reg = 1'b1;
		return t;
	endfunction

	// in-order issue rule, rs2 ignored under use_imm, rd 0 never a hazard
	function automatic logic [ISSUE_NUM_W-1:0] predict_issue(input inst_t i0, input inst_t i1,
		input logic v0, input logic v1, input logic h);
		logic dep;
		dep = i0.w_reg && i0.rd != '0 &&
			(i1.rs1 == i0.rd || (!i1.use_imm && i1.rs2 == i0.rd));
		if (h || !v0) begin
			return ISSUE_NUM_W'(0);
		end
		return (v1 && !dep) ? ISSUE_NUM_W'(2) : ISSUE_NUM_W'(1);
	endfunction

	task automatic check_commit(input string name, input commit_t exp, input commit_t act);
		if (exp !== act) begin
			err_commit++;
			$display("ERR %s commit: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_issue(input string name, input logic [ISSUE_NUM_W-1:0] exp,
		input logic [ISSUE_NUM_W-1:0] act);
		if (exp !== act) begin
			err_issue++;
			$display("ERR %s issue_num: expected %0d actual %0d", name, exp, act);
		end
	endtask

	// model retires one issued instruction, commit due 2 cycles later
	task automatic retire(input inst_t in);
		logic [XLEN-1:0] res;
		commit_t c;
		res = ref_alu(in, model_regs[in.rs1], model_regs[in.rs2]);
		if (in.w_reg && in.rd != '0) begin
			model_regs[in.rd] = res;
		end
		c.valid = 1'b1;
		c.pc = in.pc;
		c.rd = in.rd;
		c.w_reg = in.w_reg;
		c.data = res;
		exp_q.push_back(c);
		exp_cyc_q.push_back(cyc + 2);
	endtask

	// present instructions, re-present whatever did not issue
	task automatic drive_prog(input string name, input inst_t prog_in[$], input drive_mode_e mode);
		inst_t prog[$];
		inst_t i1;
		int idx;
		int k;
		int n;
		int r;
		logic v0;
		logic v1;
		logic h;
		prog = prog_in;
		test_name = name;
		foreach (prog[i]) begin
			prog[i].pc = next_pc;
			next_pc = next_pc + 32'd4;
		end
		idx = 0;
		k = 0;
		while (idx < prog.size()) begin
			@(posedge clk);
			r = $random(seed);
			i1 = (idx + 1 < prog.size()) ? prog[idx+1] : '0;
			h = (mode == M_HOLD && k >= 1 && k <= 3) || (mode == M_RAND && r[2:0] == 3'd0);
			v0 = !(mode == M_RAND && r[5:3] == 3'd0);
			v1 = v0 && mode != M_SINGLE && idx + 1 < prog.size() &&
				!(mode == M_RAND && r[7:6] == 2'd0);
			inst[0] <= prog[idx];
			inst[1] <= i1;
			inst_valid <= {v1, v0};
			hold <= h;
			// issue count is combinational, settled by the falling edge
			@(negedge clk);
			check_issue(name, predict_issue(prog[idx], i1, v0, v1, h), issue_num);
			n = int'(issue_num);
			if (n > int'(v0) + int'(v1)) begin
				n = int'(v0) + int'(v1);
			end
			for (int j = 0; j < n; j++) begin
				retire(prog[idx+j]);
			end
			idx += n;
			k++;
		end
		@(posedge clk);
		inst_valid <= '0;
		hold <= 1'b0;
		// drain until every expected commit is seen
		for (int w = 0; w < 8 && exp_q.size() > 0; w++) begin
			@(posedge clk);
		end
		if (exp_q.size() > 0) begin
			err_other++;
			$display("%s: %0d expected commits never appeared", name, exp_q.size());
			exp_q.delete();
			exp_cyc_q.delete();
		end
	endtask

	// commit monitor, pipe 0 is older within a cycle
	always @(negedge clk) begin
		commit_t e;
		if (!rst) begin
			for (int p = 0; p < PIPE_NUM; p++) begin
				if (commit[p].valid) begin
					if (exp_q.size() == 0) begin
						err_other++;
						$display("%s: unexpected commit on pipe %0d for pc %h", test_name, p,
							commit[p].pc);
					end else begin
						if (exp_cyc_q[0] != cyc) begin
							err_other++;
							$display("%s: commit for pc %h came in cycle %0d, due in cycle %0d",
								test_name, commit[p].pc, cyc, exp_cyc_q[0]);
						end
						e = exp_q.pop_front();
						void'(exp_cyc_q.pop_front());
						check_commit(test_name, e, commit[p]);
					end
				end
			end
			while (exp_q.size() > 0 && exp_cyc_q[0] < cyc) begin
				err_other++;
				$display("%s: commit for pc %h is missing", test_name, exp_q[0].pc);
				void'(exp_q.pop_front());
				void'(exp_cyc_q.pop_front());
			end
		end
	end

	task automatic build_tests();
		inst_t t;
		int r;
		// x1..x4 seeded, x4 negative via lui
		q_single.push_back(mk(ADD, 1, 0, 0, 1'b1, 100));
		q_single.push_back(mk(ADD, 2, 0, 0, 1'b1, -7));
		q_single.push_back(mk(ADD, 3, 0, 0, 1'b1, 3));
		q_single.push_back(mk(LUI, 4, 0, 0, 1'b1, 'h80000));
		for (int o = 0; o < 11; o++) begin
			q_single.push_back(mk(alu_op_e'(4'(o)), 10, 1, 2, 1'b0, 0));
			q_single.push_back(mk(alu_op_e'(4'(o)), 11, 4, 3, 1'b0, 0));
			q_single.push_back(mk(alu_op_e'(4'(o)), 12, 2, 0, 1'b1, -3));
			q_single.push_back(mk(alu_op_e'(4'(o)), 13, 4, 0, 1'b1, 5));
		end
		q_pair = '{mk(ADD, 5, 1, 2, 1'b0, 0), mk(SUB, 6, 3, 4, 1'b0, 0),
			mk(XOR, 7, 1, 3, 1'b0, 0), mk(OR, 8, 2, 0, 1'b1, 12),
			mk(AND, 9, 5, 6, 1'b0, 0), mk(SLL, 14, 7, 3, 1'b0, 0)};
		// raw pairs, then pairs through rd 0 and through an unused rs2
		q_dep = '{mk(ADD, 15, 1, 0, 1'b1, 9), mk(SUB, 16, 15, 2, 1'b0, 0),
			mk(ADD, 17, 2, 16, 1'b0, 0), mk(ADD, 0, 17, 0, 1'b1, 8),
			mk(ADD, 18, 0, 0, 1'b0, 0), mk(ADD, 19, 1, 0, 1'b1, 2),
			mk(ADD, 20, 3, 19, 1'b1, 6)};
		// rs1 reaches back d instructions
		for (int d = 1; d <= 3; d++) begin
			for (int i = 0; i < 8; i++) begin
				q_chain.push_back(mk((i % 2 == 1) ? XOR : ADD, 21 + i % 4, 21 + (i + 4 - d) % 4,
					21 + (i + 3) % 4, i % 3 == 0, i + d));
			end
		end
		t = mk(ADD, 14, 1, 1, 1'b0, 0);
		t.w_reg = 1'b0;
		q_x0 = '{mk(ADD, 0, 1, 0, 1'b1, 55), mk(ADD, 11, 0, 0, 1'b0, 0),
			mk(ADD, 12, 1, 0, 1'b1, 1), mk(ADD, 12, 2, 0, 1'b1, 2),
			mk(ADD, 13, 12, 0, 1'b1, 0), t, mk(OR, 15, 14, 0, 1'b0, 0)};
		for (int i = 0; i < 6; i++) begin
			q_hold.push_back(mk(SUB, 24 + i % 3, 1 + i % 4, 2, 1'b0, 0));
		end
		// small register window for dense hazards
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			t = mk(alu_op_e'(4'($unsigned(r) % 11)), (r >> 8) & 7, (r >> 11) & 7, (r >> 14) & 7,
				r[17], r >>> 12);
			t.w_reg = r[4:0] != 5'd0;
			q_rand.push_back(t);
		end
		total_insts = q_single.size() + q_pair.size() + q_dep.size() + 2 * q_chain.size() +
			q_x0.size() + q_hold.size() + q_rand.size();
	endtask

	initial begin
		wait (total_insts > 0);
		#((total_insts * 4 + 50) * 100);
		$display("timeout: the tests did not finish in the time allowed");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		seed = 5738;
		rst = 1'b1;
		inst = '0;
		inst_valid = '0;
		hold = 1'b0;
		next_pc = 32'h0000_1000;
		err_commit = 0;
		err_issue = 0;
		err_other = 0;
		for (int i = 0; i < REG_NUM; i++) begin
			model_regs[i] = '0;
		end
		build_tests();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		drive_prog("single_ops", q_single, M_SINGLE);
		drive_prog("indep_pairs", q_pair, M_PAIR);
		drive_prog("dep_pairs", q_dep, M_PAIR);
		drive_prog("chain_pair", q_chain, M_PAIR);
		drive_prog("chain_single", q_chain, M_SINGLE);
		drive_prog("x0_priority", q_x0, M_PAIR);
		drive_prog("hold", q_hold, M_HOLD);
		drive_prog("random", q_rand, M_RAND);
		$display("errors: commit %0d, issue %0d, other %0d", err_commit, err_issue, err_other);
		if (err_commit + err_issue + err_other == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== tb_clock.sv ====
module tb_clock (
	output logic clk_o
);

	// period 100, rising edges at 50, 150, ...
	initial begin
		clk_o = 1'b0;
		forever begin
			#50 clk_o = ~clk_o;
		end
	end

endmodule
